/* geom_pkg.sv */
`default_nettype none

package geom_pkg;

    // --------------------
    // coordinate widths
    // --------------------
    localparam int POS_W = 12;                    // integer screen coordinate
    localparam int Q_W   = 36;                    // q12.24, 12 integer + 24 fraction

    // --------------------
    // screen and duck box
    // --------------------
    localparam logic [POS_W-1:0] X_MAX       = 12'd1024; // screen width
    localparam logic [POS_W-1:0] GROUND      = 12'd620;  // ground line in y
    localparam logic [POS_W-1:0] DUCK_WIDTH  = 12'd96;
    localparam logic [POS_W-1:0] DUCK_HEIGHT = 12'd32;
    localparam logic [POS_W-1:0] X_HOME      = 12'd512;  // idle x, mid screen

    // top-left corner of the duck, or the aim point of a shot
    typedef struct packed {
        logic [POS_W-1:0] x;
        logic [POS_W-1:0] y;
    } pos_t;

endpackage

`default_nettype wire

/* game_pkg.sv */
`default_nettype none

package game_pkg;

    // --------------------
    // counter widths
    // --------------------
    localparam int AMMO_W  = 2;   // up to 3 shots per round
    localparam int SCORE_W = 16;

    // --------------------
    // payloads
    // --------------------
    // shot request from the gun side
    typedef struct packed {
        geom_pkg::pos_t aim;
    } shot_t;

    // judged shot, 43 bits
    typedef struct packed {
        logic                 hit;
        geom_pkg::pos_t       aim;         // echo of the request
        logic [AMMO_W-1:0]    ammo_left;   // ammo after this shot
        logic [SCORE_W-1:0]   score;       // score including this shot
    } result_t;

    // duck flight states
    typedef enum logic [2:0] {
        IDLE       = 3'd0,   // parked at home, game off
        SIDE       = 3'd1,   // spawn on the ground line
        UP_RIGHT   = 3'd2,
        UP_LEFT    = 3'd3,
        DOWN_RIGHT = 3'd4,
        DOWN_LEFT  = 3'd5
    } flight_t;

endpackage

`default_nettype wire

/* lfsr.sv */
`timescale 1ns/100ps
`default_nettype none

module lfsr (
    input  wire        clk,
    input  wire        rst,
    output logic [9:0] rnd
);

    // x^10 + x^7 + 1, maximal length, 1023 states
    localparam logic [9:0] SEED = 10'h2a5;   // any nonzero value

    logic feedback;

    // --------------------
    // shift register
    // --------------------
    assign feedback = rnd[9] ^ rnd[6];   // taps 10 and 7

    always_ff @(posedge clk) begin
        if (rst) begin
            rnd <= SEED;
        end else begin
            rnd <= {rnd[8:0], feedback};   // step every cycle
        end
    end

endmodule

`default_nettype wire

/* duck_ctl.sv */
`timescale 1ns/100ps
`default_nettype none

module duck_ctl #(
    parameter logic [geom_pkg::Q_W-1:0] x_speed = 36'd310,   // q12.24 step per cycle
    parameter logic [geom_pkg::Q_W-1:0] y_speed = 36'd200
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             game_enable,
    input  wire [9:0]       rnd,
    input  wire             target_killed,
    output geom_pkg::pos_t  duck_pos,
    output logic            duck_direction
);

    import geom_pkg::*;
    import game_pkg::*;

    localparam int FRAC_W = Q_W - POS_W;                              // fraction bits
    localparam logic [POS_W-1:0] X_LIM = X_MAX - DUCK_WIDTH;           // right bounce
    localparam logic [POS_W-1:0] Y_LIM = GROUND - DUCK_HEIGHT;         // ground bounce
    localparam logic [Q_W-1:0]   X_HOME_Q = {X_HOME, {FRAC_W{1'b0}}};
    localparam logic [Q_W-1:0]   GROUND_Q = {GROUND, {FRAC_W{1'b0}}};
    localparam logic [Q_W-1:0]   Y_LIM_Q  = {Y_LIM, {FRAC_W{1'b0}}};

    flight_t          state, state_nxt;
    logic [Q_W-1:0]   x_q, y_q, x_q_nxt, y_q_nxt;    // fixed point position
    logic [POS_W-1:0] x_int, y_int;                  // integer parts
    logic [POS_W-1:0] spawn_x;
    logic             heading_left, heading_up;
    logic             left_nxt, up_nxt;
    logic             at_left, at_right, at_top, at_bottom;

    assign x_int = x_q[Q_W-1 -: POS_W];
    assign y_int = y_q[Q_W-1 -: POS_W];

    // --------------------
    // bounce detection
    // --------------------
    assign heading_left = (state == UP_LEFT) || (state == DOWN_LEFT);
    assign heading_up   = (state == UP_LEFT) || (state == UP_RIGHT);

    assign at_right  = x_int >= X_LIM;
    assign at_left   = x_int == '0;
    assign at_top    = y_int == '0;
    assign at_bottom = y_int >= Y_LIM;

    // x and y turn on their own, corners flip both
    assign left_nxt = heading_left ? !at_left : at_right;
    assign up_nxt   = heading_up   ? !at_top  : at_bottom;

    // random x, pulled back if the box would leave the screen
    assign spawn_x = (rnd >= X_LIM) ? POS_W'(rnd) - DUCK_WIDTH : POS_W'(rnd);

    // --------------------
    // next state
    // --------------------
    always_comb begin
        state_nxt = state;
        if (!game_enable) begin
            state_nxt = IDLE;                    // game off parks the duck
        end else if (target_killed) begin
            state_nxt = SIDE;                    // respawn after a hit
        end else begin
            case (state)
                IDLE:    state_nxt = SIDE;
                SIDE:    state_nxt = (x_int >= (X_MAX >> 2)) ? UP_LEFT : UP_RIGHT;
                default: state_nxt = up_nxt ? (left_nxt ? UP_LEFT : UP_RIGHT)
                                            : (left_nxt ? DOWN_LEFT : DOWN_RIGHT);
            endcase
        end
    end

    // position follows the state being entered
    always_comb begin
        x_q_nxt = x_q;
        y_q_nxt = y_q;
        case (state_nxt)
            IDLE: begin
                x_q_nxt = X_HOME_Q;
                y_q_nxt = GROUND_Q;
            end
            SIDE: begin
                x_q_nxt = {spawn_x, {FRAC_W{1'b0}}};
                y_q_nxt = Y_LIM_Q;              // sits on the ground line
            end
            UP_RIGHT: begin
                x_q_nxt = x_q + x_speed;
                y_q_nxt = y_q - y_speed;
            end
            UP_LEFT: begin
                x_q_nxt = x_q - x_speed;
                y_q_nxt = y_q - y_speed;
            end
            DOWN_RIGHT: begin
                x_q_nxt = x_q + x_speed;
                y_q_nxt = y_q + y_speed;
            end
            DOWN_LEFT: begin
                x_q_nxt = x_q - x_speed;
                y_q_nxt = y_q + y_speed;
            end
            default: ;                           // hold
        endcase
    end

    // --------------------
    // registers
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            x_q   <= X_HOME_Q;
            y_q   <= GROUND_Q;
        end else begin
            state <= state_nxt;
            x_q   <= x_q_nxt;
            y_q   <= y_q_nxt;
        end
    end

    assign duck_pos       = '{x: x_int, y: y_int};
    assign duck_direction = heading_left;   // matches the last x step
endmodule

`default_nettype wire

/* shot_ctl.sv */
`timescale 1ns/100ps
`default_nettype none

module shot_ctl #(
    parameter logic [game_pkg::AMMO_W-1:0] ammo_max = 2'd3   // shots per round
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          game_enable,
    input  wire                          shot_valid,
    output logic                         shot_ready,
    input  wire game_pkg::shot_t         shot,
    input  wire                          pend_take,   // strobe from the judge
    output logic                         pend_valid,
    output game_pkg::shot_t              pend_shot,
    output logic [game_pkg::AMMO_W-1:0]  ammo_left
);

    logic accept;

    // --------------------
    // input handshake
    // --------------------
    // one slot only, ready drops while a shot waits
    assign shot_ready = game_enable && !pend_valid && (ammo_left != '0);
    assign accept     = shot_valid && shot_ready;

    // --------------------
    // pending shot
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else if (pend_take) begin
            pend_valid <= 1'b0;              // judged, slot free
        end else if (accept) begin
            pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pend_shot <= shot;               // payload, held until taken
        end
    end

    // --------------------
    // ammo count
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ammo_left <= ammo_max;
        end else if (!game_enable) begin
            ammo_left <= ammo_max;           // reload between rounds
        end else if (accept) begin
            ammo_left <= ammo_left - 1'b1;   // never below 0, ready gates it
        end
    end

endmodule

`default_nettype wire

/* hit_judge.sv */
`timescale 1ns/100ps
`default_nettype none

module hit_judge (
    input  wire                          clk,
    input  wire                          rst,
    input  wire geom_pkg::pos_t          duck_pos,
    input  wire                          pend_valid,
    input  wire game_pkg::shot_t         pend_shot,
    input  wire [game_pkg::AMMO_W-1:0]   ammo_left,
    output logic                         pend_take,
    output logic                         target_killed,
    output logic                         result_valid,
    input  wire                          result_ready,
    output game_pkg::result_t            result
);

    import geom_pkg::*;
    import game_pkg::*;

    logic               judge, hit;
    logic [POS_W:0]     x_end, y_end;    // last pixel of the box, extra bit for carry
    logic [SCORE_W-1:0] score, score_inc;

    // --------------------
    // box test
    // --------------------
    assign x_end = {1'b0, duck_pos.x} + {1'b0, DUCK_WIDTH} - 1'b1;
    assign y_end = {1'b0, duck_pos.y} + {1'b0, DUCK_HEIGHT} - 1'b1;

    assign hit = (pend_shot.aim.x >= duck_pos.x) && ({1'b0, pend_shot.aim.x} <= x_end) &&
                 (pend_shot.aim.y >= duck_pos.y) && ({1'b0, pend_shot.aim.y} <= y_end);

    // judge only into an empty result slot
    assign judge     = pend_valid && !result_valid;
    assign pend_take = judge;            // frees the shot slot at the same edge
    assign score_inc = score + 1'b1;

    // --------------------
    // control
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid  <= 1'b0;
            target_killed <= 1'b0;
            score         <= '0;
        end else begin
            target_killed <= judge && hit;    // one cycle, duck respawns
            if (judge) begin
                result_valid <= 1'b1;
            end else if (result_ready) begin
                result_valid <= 1'b0;         // handed off
            end
            if (judge && hit) begin
                score <= score_inc;
            end
        end
    end

    // result payload, stable until taken
    always_ff @(posedge clk) begin
        if (judge) begin
            result.hit       <= hit;
            result.aim       <= pend_shot.aim;
            result.ammo_left <= ammo_left;
            result.score     <= hit ? score_inc : score;
        end
    end

endmodule

`default_nettype wire

/* duck_hunt_top.sv */
`timescale 1ns/100ps
`default_nettype none

module duck_hunt_top #(
    parameter logic [geom_pkg::Q_W-1:0]    x_speed  = 36'd310,
    parameter logic [geom_pkg::Q_W-1:0]    y_speed  = 36'd200,
    parameter logic [game_pkg::AMMO_W-1:0] ammo_max = 2'd3
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   game_enable,
    // shot in
    input  wire                   shot_valid,
    output logic                  shot_ready,
    input  wire game_pkg::shot_t  shot,
    // result out
    output logic                  result_valid,
    input  wire                   result_ready,
    output game_pkg::result_t     result,
    // for display
    output geom_pkg::pos_t        duck_pos,
    output logic                  duck_direction
);

    import game_pkg::*;

    logic [9:0]        rnd;
    logic              target_killed;
    logic              pend_valid, pend_take;
    shot_t             pend_shot;
    logic [AMMO_W-1:0] ammo_left;

    // --------------------
    // duck side
    // --------------------
    lfsr u_lfsr (.clk(clk), .rst(rst), .rnd(rnd));

    duck_ctl #(.x_speed(x_speed), .y_speed(y_speed)) u_duck_ctl (
        .clk(clk), .rst(rst), .game_enable(game_enable), .rnd(rnd),
        .target_killed(target_killed), .duck_pos(duck_pos), .duck_direction(duck_direction)
    );

    // --------------------
    // shot side
    // --------------------
    shot_ctl #(.ammo_max(ammo_max)) u_shot_ctl (
        .clk(clk), .rst(rst), .game_enable(game_enable),
        .shot_valid(shot_valid), .shot_ready(shot_ready), .shot(shot),
        .pend_take(pend_take), .pend_valid(pend_valid), .pend_shot(pend_shot),
        .ammo_left(ammo_left)
    );

    hit_judge u_hit_judge (
        .clk(clk), .rst(rst), .duck_pos(duck_pos),
        .pend_valid(pend_valid), .pend_shot(pend_shot), .ammo_left(ammo_left),
        .pend_take(pend_take), .target_killed(target_killed),
        .result_valid(result_valid), .result_ready(result_ready), .result(result)
    );

endmodule

`default_nettype wire

/* tb_duck_hunt.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_duck_hunt;

    import geom_pkg::*;
    import game_pkg::*;

    localparam logic [Q_W-1:0]    SPEED   = 36'd1 << 24;   // one pixel per cycle
    localparam logic [AMMO_W-1:0] AMMO    = 2'd3;
    localparam int                TIMEOUT = 4000;          // about twice the test length
    localparam int                X_LIM   = int'(X_MAX) - int'(DUCK_WIDTH);
    localparam int                Y_LIM   = int'(GROUND) - int'(DUCK_HEIGHT);
    localparam pos_t              HOME    = '{x: X_HOME, y: GROUND};

    logic    clk = 1'b0;
    logic    rst, game_enable;
    logic    shot_valid, shot_ready, result_valid, result_ready;
    shot_t   shot;
    result_t result;
    pos_t    duck_pos;
    logic    duck_direction;
    int      seed = 33930;

    duck_hunt_top #(.x_speed(SPEED), .y_speed(SPEED), .ammo_max(AMMO)) u_dut (
        .clk(clk), .rst(rst), .game_enable(game_enable),
        .shot_valid(shot_valid), .shot_ready(shot_ready), .shot(shot),
        .result_valid(result_valid), .result_ready(result_ready), .result(result),
        .duck_pos(duck_pos), .duck_direction(duck_direction)
    );

    always #20 clk = ~clk;   // 40 ns period

    function automatic string mismatch_text(input string name, input logic [63:0] got,
                                            input logic [63:0] exp);
        return $sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    endfunction

    task automatic fail_run(input string line);
        $display(">>> FAIL");
        $display("%s", line);
        $fatal(1, "stopped at the first error");
    endtask

    // box rule, both ends included
    function automatic logic in_box(input pos_t duck, input pos_t aim);
        int x0;
        int y0;
        x0 = int'(duck.x);
        y0 = int'(duck.y);
        return int'(aim.x) >= x0 && int'(aim.x) <= x0 + int'(DUCK_WIDTH) - 1
            && int'(aim.y) >= y0 && int'(aim.y) <= y0 + int'(DUCK_HEIGHT) - 1;
    endfunction

    // --------------------
    // reference model
    // --------------------
    logic               rst_q = 1'b0;
    int unsigned        cycle = 0;
    logic               en_1, en_2, kill_1, kill_2, after_spawn;
    pos_t               last_pos;
    logic               m_pend, m_full;    // shot slot, result slot
    pos_t               m_aim;
    logic [AMMO_W-1:0]  m_ammo;
    logic [SCORE_W-1:0] m_score;
    result_t            m_res;

    always @(posedge clk) begin
        logic take, kill_now, exp_ready;
        int   exp_x;
        rst_q <= rst;
        cycle++;
        if (cycle >= TIMEOUT) begin
            fail_run($sformatf("timeout, test still running after %0d cycles", TIMEOUT));
        end
        if (rst) begin
            {en_1, en_2, kill_1, kill_2, after_spawn} = '0;
            m_pend  = 1'b0;
            m_full  = 1'b0;
            m_ammo  = AMMO;
            m_score = '0;
        end else begin
            if (!en_1) begin                            // parked at home
                assert (duck_pos == HOME && !duck_direction)
                    else fail_run(mismatch_text("duck_pos", duck_pos, HOME));
                after_spawn = 1'b0;
            end else if (!en_2 || kill_2) begin         // fresh spawn on the ground line
                assert (duck_pos.y == Y_LIM)
                    else fail_run(mismatch_text("duck_pos.y", duck_pos.y, Y_LIM));
                assert (duck_pos.x <= X_LIM && !duck_direction)
                    else fail_run("spawn x beyond the right limit or direction not cleared");
                after_spawn = 1'b1;
            end else begin
                if (after_spawn) begin                  // first heading from spawn x
                    assert (duck_direction == (last_pos.x >= X_MAX / 4))
                        else fail_run(mismatch_text("duck_direction", duck_direction,
                                                    last_pos.x >= X_MAX / 4));
                end
                exp_x = duck_direction ? last_pos.x - 1 : last_pos.x + 1;
                assert (duck_pos.x == exp_x)
                    else fail_run(mismatch_text("duck_pos.x", duck_pos.x, exp_x));
                assert (duck_pos.y == last_pos.y + 1 || duck_pos.y + 1 == last_pos.y)
                    else fail_run("duck y did not move by exactly one pixel");
                assert (duck_pos.x <= X_LIM && duck_pos.y <= Y_LIM)
                    else fail_run("duck left the bounce limits");
                after_spawn = 1'b0;
            end
            last_pos = duck_pos;

            exp_ready = game_enable && !m_pend && (m_ammo != '0);
            assert (shot_ready == exp_ready)
                else fail_run(mismatch_text("shot_ready", shot_ready, exp_ready));
            assert (result_valid == m_full)
                else fail_run(mismatch_text("result_valid", result_valid, m_full));

            take     = m_pend && !m_full;              // judge into an empty slot
            kill_now = take && in_box(duck_pos, m_aim);
            if (m_full && result_ready) begin
                assert (result == m_res)
                    else fail_run(mismatch_text("result", result, m_res));
                m_full = 1'b0;
            end
            if (take) begin
                if (kill_now) begin
                    m_score = m_score + 1'b1;
                end
                m_res  = '{hit: kill_now, aim: m_aim, ammo_left: m_ammo, score: m_score};
                m_full = 1'b1;
                m_pend = 1'b0;
            end
            if (shot_valid && exp_ready) begin
                m_pend = 1'b1;
                m_aim  = shot.aim;
            end
            if (!game_enable) begin
                m_ammo = AMMO;                          // reload between rounds
            end else if (shot_valid && exp_ready) begin
                m_ammo = m_ammo - 1'b1;
            end
            kill_2 = kill_1;
            kill_1 = kill_now;
            en_2   = en_1;
            en_1   = game_enable;
        end
    end

    // reset values, one edge after rst was seen
    assert property (@(posedge clk) rst_q |-> duck_pos == HOME && !duck_direction)
        else fail_run(mismatch_text("duck_pos", duck_pos, HOME));
    assert property (@(posedge clk) rst_q |-> !result_valid && !shot_ready)
        else fail_run("result_valid or shot_ready high during or right after reset");
    // result held while the consumer stalls
    assert property (@(posedge clk) disable iff (rst)
        $past(result_valid && !result_ready) |-> result_valid && $stable(result))
        else fail_run("result changed or dropped while result_ready was low");

    // --------------------
    // stimulus
    // --------------------
    task automatic send_shot(input pos_t aim);
        shot_valid = 1'b1;
        shot.aim   = aim;
        while (!shot_ready) begin
            @(negedge clk);
        end
        @(negedge clk);                                 // taken at the edge in between
        shot_valid = 1'b0;
    endtask

    task automatic take_result(output result_t r);
        result_ready = 1'b1;
        while (!result_valid) begin
            @(negedge clk);
        end
        r = result;
        @(negedge clk);                                 // handed over here
    endtask

    // margin of 2 keeps a one pixel move inside the box
    function automatic pos_t aim_inside(input pos_t duck);
        pos_t aim;
        aim.x = duck.x + POS_W'(2 + $unsigned($random(seed)) % 92);
        aim.y = duck.y + POS_W'(2 + $unsigned($random(seed)) % 28);
        return aim;
    endfunction

    function automatic pos_t aim_outside(input pos_t duck);
        pos_t aim;
        aim.x = POS_W'($unsigned($random(seed)) % 1024);
        aim.y = (duck.y >= 12'd300) ? duck.y - 12'd100 : duck.y + 12'd100;
        return aim;
    endfunction

    task automatic restart_round();
        game_enable = 1'b0;
        repeat (3) @(negedge clk);
        game_enable = 1'b1;
        repeat (3) @(negedge clk);
    endtask

    initial begin
        result_t            r, r2;
        pos_t               a, b;
        logic [SCORE_W-1:0] score_seen;
        rst          = 1'b1;
        game_enable  = 1'b0;
        shot_valid   = 1'b0;
        shot         = '0;
        result_ready = 1'b1;
        score_seen   = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);

        game_enable = 1'b1;
        repeat (1900) @(negedge clk);                   // top and side bounces

        for (int i = 0; i < int'(AMMO); i++) begin       // hits
            send_shot(aim_inside(duck_pos));
            take_result(r);
            assert (r.hit) else fail_run(mismatch_text("result.hit", r.hit, 1'b1));
            assert (r.score == score_seen + 1'b1)
                else fail_run(mismatch_text("result.score", r.score, score_seen + 1'b1));
            score_seen = r.score;
            repeat (3) @(negedge clk);
        end

        shot_valid = 1'b1;                              // no ammo left
        repeat (10) begin
            @(negedge clk);
            assert (!shot_ready) else fail_run(mismatch_text("shot_ready", shot_ready, 1'b0));
        end
        shot_valid = 1'b0;

        restart_round();
        for (int i = 1; i <= int'(AMMO); i++) begin      // misses
            send_shot(aim_outside(duck_pos));
            take_result(r);
            assert (!r.hit) else fail_run(mismatch_text("result.hit", r.hit, 1'b0));
            assert (int'(r.ammo_left) == int'(AMMO) - i)
                else fail_run(mismatch_text("result.ammo_left", r.ammo_left, int'(AMMO) - i));
        end

        restart_round();
        result_ready = 1'b0;                            // back-pressure
        a = aim_inside(duck_pos);
        send_shot(a);
        b = aim_inside(duck_pos);
        send_shot(b);
        repeat (8) begin
            @(negedge clk);
            assert (!shot_ready && result_valid)
                else fail_run("second shot not held back while the first result waits");
        end
        take_result(r);
        take_result(r2);
        assert (r.aim == a) else fail_run(mismatch_text("result.aim", r.aim, a));
        assert (r2.aim == b) else fail_run(mismatch_text("result.aim", r2.aim, b));

        repeat (5) @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
geom_pkg.sv
game_pkg.sv
lfsr.sv
duck_ctl.sv
shot_ctl.sv
hit_judge.sv
duck_hunt_top.sv
tb_duck_hunt.sv

/* run.sh */
#!/bin/sh
# compile and run the duck hunt testbench with verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module tb_duck_hunt -f list.f \
    && ./obj_dir/Vtb_duck_hunt | tee /dev/stderr | grep -q ">>> PASS" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
